//--- vlog.f
hw/md_pair_pkg.sv
hw/home_pos_cache.sv
hw/sweep_counter.sv
hw/pair_sweep_fsm.sv
hw/pos_data_distributor.sv
hw/pair_sched_top.sv
testbench/tb_pair_sched.sv

//--- testbench/tb_pair_sched.sv
// Self-checking testbench for the home-cell pair scheduler
// Six sweeps with LFSR counts, stalls and done levels; concurrent checks compare with a model
`timescale 1ns/1ns

module tb_pair_sched;

	import md_pair_pkg::*;

	localparam int NF = 7;
	localparam int PW = 7;
	localparam int NT = 6;

	typedef logic [2*NF-1:0][PW:0] count_arr_t;

	logic                  clk = 1'b0;
	logic                  arst_n;
	logic                  wr_en;
	logic [PW-1:0]         wr_addr;
	offset_pos_t           wr_pos;
	logic                  start;
	logic [PW:0]           home_count;
	count_arr_t            ref_count;
	logic                  pause;
	logic [2*NF-1:0]       broadcast_done;
	tagged_pos_t           out_pos;
	logic [NF-1:0]         pair_valid;
	logic [PW-1:0]         out_home_idx;
	logic [PW-1:0]         out_ref_idx;
	logic                  out_phase;
	logic                  busy;
	logic                  done;

	// Reference model of the sweep and of the loaded cache
	offset_pos_t           pos_model [2**PW];
	offset_pos_t           home_word;
	tagged_pos_t           exp_pos;
	bit                    cov [2][2**PW][2**PW];
	logic                  exp_run;
	logic                  exp_fin;
	int                    issued;
	logic                  out_issue;
	logic                  exp_phase = 1'b0;
	int                    exp_ref = 0;
	int                    exp_home = 0;
	int                    cov_count = 0;
	logic [NF-1:0]         exp_mask;
	int                    lim0 = 1;
	int                    lim1 = 1;
	int                    exp_total = 0;

	// Run bookkeeping
	logic [31:0]           lfsr;
	int                    err_count = 0;
	int                    cycle = 0;
	int                    limit = 1 << 30;
	int                    cur_test = 0;
	int                    t_hc [NT];
	count_arr_t            t_rc [NT];
	string                 names [NT] = '{"load_and_tag", "sweep_order", "mask_rule",
		"home_self_pair", "back_pressure", "stale_restart"};

	pair_sched_top #(.NUM_FILTER(NF), .PARTICLE_ID_WIDTH(PW)) dut_i (.*);

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR that steps once for every bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// Largest count among the cells of a phase with a floor of one pass
	function automatic int calc_limit(input count_arr_t rc, input int ph);
		int m;
		m = 1;
		for (int f = 0; f < NF; f++)
			if (rc[ph*NF+f] > m)
				m = rc[ph*NF+f];
		return m;
	endfunction

	function automatic void report_err(input string msg);
		$display("ERR t=%0t %s", $time, msg);
		err_count++;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Model
	////////////////////////////////////////////////////////////////////////////

	// The sweep runs from the cycle after start until the last of exp_total
	// combinations is issued, and a combination reaches the outputs one cycle
	// after an unpaused sweep cycle
	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			exp_run   <= 1'b0;
			exp_fin   <= 1'b0;
			issued    <= 0;
			out_issue <= 1'b0;
		end
		else
		begin
			out_issue <= exp_run && !pause;
			exp_fin   <= exp_run && !pause && (issued == exp_total - 1);
			if (start && !exp_run && !exp_fin)
			begin
				exp_run <= 1'b1;
				issued  <= 0;
			end
			else if (exp_run && !pause)
			begin
				issued <= issued + 1;
				if (issued == exp_total - 1)
					exp_run <= 1'b0;
			end
		end
	end

	// Expected next combination with the home index running fastest and the
	// phase slowest
	always @(posedge clk)
	begin
		if (start)
		begin
			for (int p = 0; p < 2; p++)
				for (int r = 0; r < 2**PW; r++)
					for (int h = 0; h < 2**PW; h++)
						cov[p][r][h] <= 1'b0;
			cov_count <= 0;
			exp_phase <= 1'b0;
			exp_ref   <= 0;
			exp_home  <= 0;
		end
		else if (out_issue)
		begin
			cov[out_phase][out_ref_idx][out_home_idx] <= 1'b1;
			cov_count <= cov_count + 1;
			if (exp_home == home_count - 1)
			begin
				exp_home <= 0;
				if (exp_ref == (exp_phase ? lim1 : lim0) - 1)
				begin
					exp_ref   <= 0;
					exp_phase <= 1'b1;
				end
				else
					exp_ref <= exp_ref + 1;
			end
			else
				exp_home <= exp_home + 1;
		end
	end

	// Slot must hold a particle, its cell must still broadcast, and the home
	// filter keeps only pairs with home above ref
	always_comb
	begin
		for (int f = 0; f < NF; f++)
			exp_mask[f] = out_issue && (exp_ref < ref_count[exp_phase*NF+f])
				&& !broadcast_done[exp_phase*NF+f]
				&& (f != 0 || exp_phase || exp_home > exp_ref);
	end

	// Each coordinate gets the home id on top and z sits in the high word
	assign home_word = pos_model[out_home_idx];
	assign exp_pos = {HOME_CELL_ID, home_word.z, HOME_CELL_ID, home_word.y,
		HOME_CELL_ID, home_word.x};

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	a_order: assert property (@(posedge clk) disable iff (!arst_n)
		out_issue |-> (out_phase == exp_phase && out_ref_idx == exp_ref
			&& out_home_idx == exp_home))
	else report_err("combination out of sweep order");

	a_once: assert property (@(posedge clk) disable iff (!arst_n)
		out_issue |-> !cov[out_phase][out_ref_idx][out_home_idx])
	else report_err("combination issued twice");

	a_mask: assert property (@(posedge clk) disable iff (!arst_n) pair_valid == exp_mask)
	else report_err("pair_valid differs from mask rule");

	a_self: assert property (@(posedge clk) disable iff (!arst_n)
		(pair_valid[0] && !out_phase) |-> (out_home_idx > out_ref_idx))
	else report_err("home self or mirrored pair marked valid");

	a_pos: assert property (@(posedge clk) disable iff (!arst_n)
		(|pair_valid) |-> (out_pos == exp_pos))
	else report_err("out_pos differs from loaded position");

	a_pause: assert property (@(posedge clk) disable iff (!arst_n)
		pause |=> (pair_valid == '0))
	else report_err("mask not empty after paused cycle");

	a_done_last: assert property (@(posedge clk) disable iff (!arst_n)
		done |-> (out_issue && exp_phase && exp_ref == lim1 - 1
			&& exp_home == home_count - 1 && cov_count == exp_total - 1))
	else report_err("done without the last combination on the outputs");

	a_done_once: assert property (@(posedge clk) disable iff (!arst_n)
		done |=> (!done && !busy))
	else report_err("done longer than one cycle or busy still high");

	a_status: assert property (@(posedge clk) disable iff (!arst_n)
		(busy == (exp_run || exp_fin)) && (done == exp_fin))
	else report_err("busy or done differs from the expected sweep state");

	a_idle: assert property (@(posedge clk) disable iff (!arst_n)
		!busy |-> (!done && pair_valid == '0))
	else report_err("activity while idle");

	// Watchdog over the whole run
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= limit)
		begin
			$display("Timeout: test %0d (%s) never reached done within %0d cycles",
				cur_test, names[cur_test], limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic run_test(input int t, inout int n_pass, inout int n_fail);
		int          errs_before;
		logic        done_seen;
		logic [31:0] v;
		offset_pos_t p;
		errs_before = err_count;
		done_seen   = 1'b0;
		cur_test    = t;
		// The last test sweeps whatever the previous one left in the cache
		if (t != 5)
		begin
			for (int i = 0; i < t_hc[t]; i++)
			begin
				p.x = rand_bits(OFFSET_WIDTH);
				p.y = rand_bits(OFFSET_WIDTH);
				p.z = rand_bits(OFFSET_WIDTH);
				@(posedge clk);
				wr_en   <= 1'b1;
				wr_addr <= PW'(i);
				wr_pos  <= p;
				pos_model[i] = p;
			end
		end
		@(posedge clk);
		wr_en      <= 1'b0;
		home_count <= (PW+1)'(t_hc[t]);
		ref_count  <= t_rc[t];
		lim0      = calc_limit(t_rc[t], 0);
		lim1      = calc_limit(t_rc[t], 1);
		exp_total = t_hc[t] * (lim0 + lim1);
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (!done_seen)
		begin
			v = rand_bits(2);
			pause <= (t == 4) && (v[1:0] == 2'b11);
			if (t == 2 || t == 4)
				broadcast_done <= rand_bits(2*NF);
			@(posedge clk);
			done_seen = done;
		end
		pause          <= 1'b0;
		broadcast_done <= '0;
		@(posedge clk);
		if (err_count == errs_before)
		begin
			n_pass++;
			$display("test %0d %s: passed", t, names[t]);
		end
		else
		begin
			n_fail++;
			$display("test %0d %s: failed with %0d errors", t, names[t], err_count - errs_before);
		end
	endtask

	initial
	begin
		int n_pass;
		int n_fail;
		n_pass         = 0;
		n_fail         = 0;
		lfsr           = 32'd74132;
		arst_n         = 1'b0;
		wr_en          = 1'b0;
		wr_addr        = '0;
		wr_pos         = '0;
		start          = 1'b0;
		home_count     = 8'd1;
		ref_count      = '0;
		pause          = 1'b0;
		broadcast_done = '0;
		// All counts are drawn up front so the run limit is known before the first sweep
		limit = 16;
		for (int t = 0; t < NT; t++)
		begin
			t_hc[t] = 1 + rand_bits(4);
			for (int c = 0; c < 2*NF; c++)
				t_rc[t][c] = (PW+1)'(rand_bits(4));
			if (t == 3)
				t_rc[t][0] = (PW+1)'(t_hc[t]);
			if (t == 5)
			begin
				t_hc[t] = t_hc[4];
				t_rc[t] = t_rc[4];
			end
			limit += 2 * t_hc[t] * (calc_limit(t_rc[t], 0) + calc_limit(t_rc[t], 1)) + 200;
		end
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		for (int t = 0; t < NT; t++)
			run_test(t, n_pass, n_fail);
		$display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0 && err_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- hw/pair_sched_top.sv
// Home-cell pair scheduler of the force engine
// Load the home cell, pulse start, and collect one tagged position per output cycle
`timescale 1ns/1ns

module pair_sched_top
#(
	parameter int NUM_FILTER        = 7,
	parameter int PARTICLE_ID_WIDTH = 7
)
(
	input  logic                                         clk,
	input  logic                                         arst_n,
	// Home cell load port
	input  logic                                         wr_en,
	input  logic [PARTICLE_ID_WIDTH-1:0]                 wr_addr,
	input  md_pair_pkg::offset_pos_t                     wr_pos,
	// Sweep control and cell occupancy
	input  logic                                         start,
	input  logic [PARTICLE_ID_WIDTH:0]                   home_count,
	input  logic [2*NUM_FILTER-1:0][PARTICLE_ID_WIDTH:0] ref_count,
	// Levels from the filter and broadcast stages
	input  logic                                         pause,
	input  logic [2*NUM_FILTER-1:0]                      broadcast_done,
	// Output stream
	output md_pair_pkg::tagged_pos_t                     out_pos,
	output logic [NUM_FILTER-1:0]                        pair_valid,
	output logic [PARTICLE_ID_WIDTH-1:0]                 out_home_idx,
	output logic [PARTICLE_ID_WIDTH-1:0]                 out_ref_idx,
	output logic                                         out_phase,
	output logic                                         busy,
	output logic                                         done
);

	import md_pair_pkg::*;

	sweep_state_t                 state;
	logic [PARTICLE_ID_WIDTH-1:0] home_idx;
	logic [PARTICLE_ID_WIDTH-1:0] ref_idx;
	logic                         phase_last;
	logic [NUM_FILTER-1:0]        ref_slot_valid;
	logic                         ref_read;
	logic                         issue;
	logic                         rd_en;
	logic                         phase;
	offset_pos_t                  rd_pos;

	// Every issued combination reads its home particle once
	assign rd_en = issue;
	assign phase = (state == S_PHASE1);

	home_pos_cache #(.PARTICLE_ID_WIDTH(PARTICLE_ID_WIDTH)) cache_i (
		.clk(clk), .arst_n(arst_n),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_pos(wr_pos),
		.rd_en(rd_en), .rd_addr(home_idx), .rd_pos(rd_pos)
	);

	sweep_counter #(.NUM_FILTER(NUM_FILTER), .PARTICLE_ID_WIDTH(PARTICLE_ID_WIDTH)) counter_i (
		.clk(clk), .arst_n(arst_n), .state(state), .pause(pause),
		.home_count(home_count), .ref_count(ref_count),
		.home_idx(home_idx), .ref_idx(ref_idx), .phase_last(phase_last),
		.ref_slot_valid(ref_slot_valid), .ref_read(ref_read), .issue(issue)
	);

	pair_sweep_fsm fsm_i (
		.clk(clk), .arst_n(arst_n), .start(start), .phase_last(phase_last),
		.state(state), .busy(busy), .done(done)
	);

	pos_data_distributor #(.NUM_FILTER(NUM_FILTER), .PARTICLE_ID_WIDTH(PARTICLE_ID_WIDTH)) dist_i (
		.clk(clk), .arst_n(arst_n), .issue(issue), .phase(phase),
		.ref_slot_valid(ref_slot_valid), .ref_read(ref_read),
		.home_idx(home_idx), .ref_idx(ref_idx), .rd_pos(rd_pos),
		.broadcast_done(broadcast_done), .out_pos(out_pos), .pair_valid(pair_valid),
		.out_home_idx(out_home_idx), .out_ref_idx(out_ref_idx), .out_phase(out_phase)
	);

endmodule

//--- hw/pos_data_distributor.sv
// Output stage that pairs each cache read with its delayed control
// Tags the home position with the home cell id and forms the per-filter mask
`timescale 1ns/1ns

module pos_data_distributor
#(
	parameter int NUM_FILTER        = 7,
	parameter int PARTICLE_ID_WIDTH = 7
)
(
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         issue,
	input  logic                         phase,
	input  logic [NUM_FILTER-1:0]        ref_slot_valid,
	input  logic                         ref_read,
	input  logic [PARTICLE_ID_WIDTH-1:0] home_idx,
	input  logic [PARTICLE_ID_WIDTH-1:0] ref_idx,
	// Position read one cycle after issue
	input  md_pair_pkg::offset_pos_t     rd_pos,
	// Sampled live, in the output cycle itself
	input  logic [2*NUM_FILTER-1:0]      broadcast_done,
	output md_pair_pkg::tagged_pos_t     out_pos,
	output logic [NUM_FILTER-1:0]        pair_valid,
	output logic [PARTICLE_ID_WIDTH-1:0] out_home_idx,
	output logic [PARTICLE_ID_WIDTH-1:0] out_ref_idx,
	output logic                         out_phase
);

	import md_pair_pkg::*;

	logic                  issue_q;
	logic [NUM_FILTER-1:0] slot_valid_q;
	logic                  ref_read_q;

	// One stage of delay to sit beside the registered cache read
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			issue_q      <= 1'b0;
			out_phase    <= 1'b0;
			slot_valid_q <= '0;
			ref_read_q   <= 1'b0;
			out_home_idx <= '0;
			out_ref_idx  <= '0;
		end
		else
		begin
			issue_q      <= issue;
			out_phase    <= phase;
			slot_valid_q <= ref_slot_valid;
			ref_read_q   <= ref_read;
			out_home_idx <= home_idx;
			out_ref_idx  <= ref_idx;
		end
	end

	// Every coordinate comes from the home cell, so all three get its id
	always_comb
	begin
		out_pos.x = '{cell_id: HOME_CELL_ID, offset: rd_pos.x};
		out_pos.y = '{cell_id: HOME_CELL_ID, offset: rd_pos.y};
		out_pos.z = '{cell_id: HOME_CELL_ID, offset: rd_pos.z};
	end

	// A cell that finished broadcasting has no reference left to pair with;
	// filter 0 in phase 0 holds a home particle and needs the half-pair rule
	always_comb
	begin
		for (int f = 0; f < NUM_FILTER; f++)
			pair_valid[f] = issue_q && slot_valid_q[f]
				&& !broadcast_done[out_phase ? NUM_FILTER + f : f];
		if (!out_phase)
			pair_valid[0] = pair_valid[0] && ref_read_q;
	end

	// The home filter pairs a particle only with a lower ref index, checked
	// against the delayed indices rather than the counter's compare
	a_home_pair_above_ref: assert property (
		@(posedge clk) disable iff (!arst_n)
		(pair_valid[0] && !out_phase) |-> (out_home_idx > out_ref_idx)
	)
	else $error("pos_data_distributor: home filter valid without home above ref");

endmodule

//--- hw/pair_sweep_fsm.sv
// Sequencer for the two-phase pair sweep
// Leaves idle on a start pulse and closes with a single done cycle
`timescale 1ns/1ns

module pair_sweep_fsm
(
	input  logic                      clk,
	input  logic                      arst_n,
	// One-cycle pulse, ignored unless idle
	input  logic                      start,
	// Last combination of the current phase is being issued
	input  logic                      phase_last,
	output md_pair_pkg::sweep_state_t state,
	output logic                      busy,
	output logic                      done
);

	import md_pair_pkg::*;

	sweep_state_t state_nxt;

	////////////////////////////////////////////////////////////////////////////
	// Next-state logic
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		case (state)
			S_IDLE:
			begin
				// The first combination is issued in the cycle after start
				if (start)
					state_nxt = S_PHASE0;
			end
			S_PHASE0:
			begin
				// Phase 1 follows directly with no gap cycle
				if (phase_last)
					state_nxt = S_PHASE1;
			end
			S_PHASE1:
			begin
				if (phase_last)
					state_nxt = S_FINISH;
			end
			S_FINISH:
			begin
				// One cycle only, while the last combination is on the outputs
				state_nxt = S_IDLE;
			end
			default:
			begin
				state_nxt = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= S_IDLE;
		else
			state <= state_nxt;
	end

	////////////////////////////////////////////////////////////////////////////
	// Status outputs
	////////////////////////////////////////////////////////////////////////////

	// busy covers the finish cycle too, so it drops right after done
	assign busy = (state != S_IDLE);

	// The output stage trails issue by one cycle, which lines done up with
	// the final combination
	assign done = (state == S_FINISH);

	// The counter must stay quiet while no sweep is running
	a_no_phase_last_idle: assert property (
		@(posedge clk) disable iff (!arst_n)
		(state == S_IDLE) |-> !phase_last
	)
	else $error("pair_sweep_fsm: phase_last seen while idle");

endmodule

//--- hw/sweep_counter.sv
// Nested home and reference indices for the pair sweep
// Also derives the per-phase reference limit and the per-filter slot validity
`timescale 1ns/1ns

module sweep_counter
#(
	parameter int NUM_FILTER        = 7,
	parameter int PARTICLE_ID_WIDTH = 7
)
(
	input  logic                                         clk,
	input  logic                                         arst_n,
	input  md_pair_pkg::sweep_state_t                    state,
	input  logic                                         pause,
	// Particle count of the home cell, never zero when a sweep starts
	input  logic [PARTICLE_ID_WIDTH:0]                   home_count,
	// Particle count of every cell, home cell first
	input  logic [2*NUM_FILTER-1:0][PARTICLE_ID_WIDTH:0] ref_count,
	output logic [PARTICLE_ID_WIDTH-1:0]                 home_idx,
	output logic [PARTICLE_ID_WIDTH-1:0]                 ref_idx,
	output logic                                         phase_last,
	output logic [NUM_FILTER-1:0]                        ref_slot_valid,
	output logic                                         ref_read,
	output logic                                         issue
);

	import md_pair_pkg::*;

	logic                       phase;
	logic                       active;
	logic [PARTICLE_ID_WIDTH:0] ref_limit;
	logic                       home_last;
	logic                       ref_last;

	////////////////////////////////////////////////////////////////////////////
	// Phase decode and limits
	////////////////////////////////////////////////////////////////////////////

	// Phase 1 serves the upper half of the cell list
	assign phase  = (state == S_PHASE1);
	assign active = (state == S_PHASE0) || (state == S_PHASE1);

	// A paused cycle presents nothing and the indices hold
	assign issue = active && !pause;

	// The reference loop runs as long as the fullest cell of this phase, and
	// at least once so an all-empty phase still closes cleanly
	always_comb
	begin
		ref_limit = '0;
		for (int f = 0; f < NUM_FILTER; f++)
		begin
			if (ref_count[phase ? NUM_FILTER + f : f] > ref_limit)
				ref_limit = ref_count[phase ? NUM_FILTER + f : f];
		end
		if (ref_limit == '0)
			ref_limit = 1;
	end

	assign home_last  = ({1'b0, home_idx} == home_count - 1'b1);
	assign ref_last   = ({1'b0, ref_idx} == ref_limit - 1'b1);
	assign phase_last = issue && home_last && ref_last;

	// A filter only has a particle when its cell still holds one at ref_idx
	always_comb
	begin
		for (int f = 0; f < NUM_FILTER; f++)
			ref_slot_valid[f] = ({1'b0, ref_idx} < ref_count[phase ? NUM_FILTER + f : f]);
	end

	// Home-home pairs are kept only for home above ref, which drops the self
	// pair and the mirrored duplicate in one compare
	assign ref_read = (home_idx > ref_idx);

	////////////////////////////////////////////////////////////////////////////
	// Index registers
	////////////////////////////////////////////////////////////////////////////

	// Home runs fastest; both indices clear at the end of a phase, so the
	// next phase starts from the first combination
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			home_idx <= '0;
			ref_idx  <= '0;
		end
		else if (!active || phase_last)
		begin
			home_idx <= '0;
			ref_idx  <= '0;
		end
		else if (issue)
		begin
			if (home_last)
			begin
				home_idx <= '0;
				ref_idx  <= ref_idx + 1'b1;
			end
			else
				home_idx <= home_idx + 1'b1;
		end
	end

	// An empty home cell would never reach home_last and the sweep would hang
	a_home_count_nonzero: assert property (
		@(posedge clk) disable iff (!arst_n)
		(state == S_IDLE) ##1 (state == S_PHASE0) |-> (home_count != '0)
	)
	else $error("sweep_counter: sweep started with home_count of zero");

	// home_count may only change while idle; otherwise the index runs past it
	a_home_idx_in_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		issue |-> ({1'b0, home_idx} < home_count)
	)
	else $error("sweep_counter: home_idx reached home_count");

endmodule

//--- hw/home_pos_cache.sv
// Position memory for the particles of the home cell
// Loaded through the write port before a sweep, then read once per combination
`timescale 1ns/1ns

module home_pos_cache
#(
	parameter int PARTICLE_ID_WIDTH = 7
)
(
	input  logic                         clk,
	input  logic                         arst_n,
	// Load port, used while the scheduler is idle
	input  logic                         wr_en,
	input  logic [PARTICLE_ID_WIDTH-1:0] wr_addr,
	input  md_pair_pkg::offset_pos_t     wr_pos,
	// Read port, driven by the sweep counter
	input  logic                         rd_en,
	input  logic [PARTICLE_ID_WIDTH-1:0] rd_addr,
	output md_pair_pkg::offset_pos_t     rd_pos
);

	import md_pair_pkg::*;

	// One entry per particle slot of the home cell
	localparam int DEPTH = 2 ** PARTICLE_ID_WIDTH;

	offset_pos_t mem [DEPTH];

	////////////////////////////////////////////////////////////////////////////
	// Write and read ports
	////////////////////////////////////////////////////////////////////////////

	// Plain synchronous write
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_pos;
	end

	// Registered read; the word stays put while the sweep is paused, so a
	// held output never shows a different particle than the one last issued
	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_pos <= mem[rd_addr];
	end

	// Loading must not overlap a running sweep, or a filter may see a mix of
	// the old and new particle in the same position word
	a_no_write_during_read: assert property (
		@(posedge clk) disable iff (!arst_n)
		rd_en |-> !wr_en
	)
	else $error("home_pos_cache: write while a sweep is reading");

endmodule

//--- hw/md_pair_pkg.sv
// Shared constants and types for the home-cell pair scheduler
// Every RTL block that handles positions, cell tags or the sweep state imports this
package md_pair_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Coordinate widths
	////////////////////////////////////////////////////////////////////////////

	// Fixed-point offset of one coordinate inside its cell
	localparam int OFFSET_WIDTH = 29;

	// Cell coordinate id along one axis of the 3x3x3 neighbourhood
	localparam int CELL_ID_WIDTH = 3;

	// One coordinate word as it leaves the scheduler, id on top of the offset
	localparam int TAGGED_WIDTH = CELL_ID_WIDTH + OFFSET_WIDTH;

	// The home cell sits in the middle slot of every axis
	localparam logic [CELL_ID_WIDTH-1:0] HOME_CELL_ID = 3'd2;

	////////////////////////////////////////////////////////////////////////////
	// Position words
	////////////////////////////////////////////////////////////////////////////

	// Raw cache word, x sits in the low bits so the memory layout matches the
	// position RAMs of the force engine
	typedef struct packed
	{
		logic [OFFSET_WIDTH-1:0] z;
		logic [OFFSET_WIDTH-1:0] y;
		logic [OFFSET_WIDTH-1:0] x;
	} offset_pos_t;

	// One coordinate carrying the id of the cell it was read from
	typedef struct packed
	{
		logic [CELL_ID_WIDTH-1:0] cell_id;
		logic [OFFSET_WIDTH-1:0]  offset;
	} tagged_coord_t;

	// Full tagged position handed to the force filters
	typedef struct packed
	{
		tagged_coord_t z;
		tagged_coord_t y;
		tagged_coord_t x;
	} tagged_pos_t;

	////////////////////////////////////////////////////////////////////////////
	// Sweep sequencing
	////////////////////////////////////////////////////////////////////////////

	// Idle, the two half-shell phases, and one closing cycle for the last output
	typedef enum logic [1:0]
	{
		S_IDLE   = 2'd0,
		S_PHASE0 = 2'd1,
		S_PHASE1 = 2'd2,
		S_FINISH = 2'd3
	} sweep_state_t;

endpackage
